//--- project.f
common/bridge_pkg.sv
verilog/bridge_tick_gen.sv
i2c_bridge/i2c_line_bridge.sv
i2c_bridge/i2c_bus_monitor.sv
verilog/bridge_regs.sv
verilog/i2c_bridge_top.sv
tests/tb_clk_gen.sv
tests/tb_i2c_bridge.sv

//--- Bender.yml
package:
  name: i2c_bridge

sources:
  - common/bridge_pkg.sv
  - verilog/bridge_tick_gen.sv
  - i2c_bridge/i2c_line_bridge.sv
  - i2c_bridge/i2c_bus_monitor.sv
  - verilog/bridge_regs.sv
  - verilog/i2c_bridge_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_i2c_bridge.sv

//--- tests/tb_i2c_bridge.sv
`timescale 1ns/1ps

module tb_i2c_bridge
    import bridge_pkg::*;
;

    localparam logic [15:0] DIV = 16'd8;
    localparam int BOUND       = 2 * (DIV + 5); // bridged edge limit
    localparam int RAND_STEPS  = 40;
    localparam int NUM_OPS     = 2 * RAND_STEPS + 40;
    localparam int CYCLE_LIMIT = NUM_OPS * BOUND + 500;

    logic          clk;
    logic          rst;
    axi_lite_req_t req;
    axi_lite_rsp_t rsp;
    logic          a_sda_in;
    logic          a_scl_in;
    logic          b_sda_in;
    logic          b_scl_in;
    logic          a_sda_pull;
    logic          a_scl_pull;
    logic          b_sda_pull;
    logic          b_scl_pull;
    logic [3:0]    dev_low;    // device pulls: a_sda, a_scl, b_sda, b_scl
    logic [15:0]   lfsr;
    logic          sda_hist [0:RAND_STEPS]; // bus levels after each random step
    logic          scl_hist [0:RAND_STEPS];
    int            value_errors = 0;
    int            other_errors = 0;
    int            cycle_cnt;

    tb_clk_gen #(.PERIOD(10.0), .RESET_CYCLES(10)) clk_gen_inst (.clk(clk), .rst(rst));

    // wired-and with pull-up, low if either end pulls
    assign a_sda_in = !(a_sda_pull || dev_low[0]);
    assign a_scl_in = !(a_scl_pull || dev_low[1]);
    assign b_sda_in = !(b_sda_pull || dev_low[2]);
    assign b_scl_in = !(b_scl_pull || dev_low[3]);

    i2c_bridge_top #(.DEFAULT_DIV(DIV)) i2c_bridge_top_inst (
        .clk       (clk),
        .rst       (rst),
        .axi_req   (req),
        .axi_rsp   (rsp),
        .a_sda_in  (a_sda_in),
        .a_scl_in  (a_scl_in),
        .b_sda_in  (b_sda_in),
        .b_scl_in  (b_scl_in),
        .a_sda_pull(a_sda_pull),
        .a_scl_pull(a_scl_pull),
        .b_sda_pull(b_sda_pull),
        .b_scl_pull(b_scl_pull)
    );

    initial
    begin
        req     = '0;
        dev_low = 4'b0000; // every device released
    end

    task automatic step_clk();
        @(posedge clk);
        #1; // inputs change 1 ns after the edge
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) step_clk();
    endtask

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr); // one step per bit
        b    = lfsr[0];
    endtask

    // expected START (want_start) or STOP count over the recorded levels
    function automatic int count_conditions(input int steps, input logic want_start);
        int n;
        n = 0;
        for (int i = 1; i <= steps; i++)
        begin
            if (scl_hist[i] && (sda_hist[i] != sda_hist[i-1]) && (sda_hist[i] == !want_start))
                n++; // sda moved while scl high
        end
        return n;
    endfunction

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold,
                             output logic [1:0] resp);
        logic aw_done;
        logic w_done;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        while (req.awvalid || req.wvalid)
        begin
            aw_done = req.awvalid && rsp.awready; // ready is stable mid-cycle
            w_done  = req.wvalid && rsp.wready;
            step_clk();
            if (aw_done)
                req.awvalid = 1'b0;
            if (w_done)
                req.wvalid = 1'b0;
        end
        while (!rsp.bvalid)
            step_clk();
        for (int i = 0; i < hold; i++)
        begin
            step_clk(); // bready still low
            if (!rsp.bvalid)
            begin
                $display("write response to %h dropped while bready was low, t=%0t", addr, $time);
                other_errors++;
            end
        end
        req.bready = 1'b1;
        resp       = rsp.bresp;
        step_clk();
        req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int hold, output logic [31:0] data,
                            output logic [1:0] resp);
        logic [31:0] first;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        while (!rsp.arready)
            step_clk();
        step_clk();
        req.arvalid = 1'b0;
        while (!rsp.rvalid)
            step_clk();
        first = rsp.rdata;
        for (int i = 0; i < hold; i++)
        begin
            step_clk();
            if (!rsp.rvalid || rsp.rdata !== first)
            begin
                $display("read data from %h changed while rready was low, t=%0t", addr, $time);
                other_errors++;
            end
        end
        req.rready = 1'b1;
        data       = rsp.rdata;
        resp       = rsp.rresp;
        step_clk();
        req.rready = 1'b0;
    endtask

    function automatic logic pull_of(input int idx);
        case (idx)
            0:       return a_sda_pull;
            1:       return a_scl_pull;
            2:       return b_sda_pull;
            default: return b_scl_pull;
        endcase
    endfunction

    task automatic expect_pull(input int idx, input logic level, input string name);
        int n;
        n = 0;
        while (pull_of(idx) !== level && n < BOUND)
        begin
            step_clk();
            n++;
        end
        if (pull_of(idx) !== level)
        begin
            $display("%s did not reach %0b within %0d cycles, t=%0t", name, level, BOUND, $time);
            other_errors++;
        end
    endtask

    // bridge disabled, nothing may be driven
    task automatic expect_quiet(input int n);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < n; i++)
        begin
            step_clk();
            seen = seen | a_sda_pull | a_scl_pull | b_sda_pull | b_scl_pull;
        end
        if (seen)
        begin
            $display("a pull was driven while the bridge was disabled, t=%0t", $time);
            other_errors++;
        end
    endtask

    initial
    begin : main
        logic [31:0] rd;
        logic [1:0]  resp;
        logic        side;
        logic        line;
        logic        dir;
        wait_cycles(3);
        check_equal("rsp valid/ready in reset", 32'd0,
                    {rsp.awready, rsp.wready, rsp.bvalid, rsp.arready, rsp.rvalid});
        while (rst)
            step_clk();

        // reset state
        check_equal("pulls", 32'd0, {a_sda_pull, a_scl_pull, b_sda_pull, b_scl_pull});
        axi_read(REG_CTRL, 0, rd, resp);
        check_equal("ctrl", {DIV, 16'd0}, rd);
        axi_read(REG_STATUS, 0, rd, resp);
        check_equal("status", 32'd0, rd);
        axi_read(REG_START_CNT, 0, rd, resp);
        check_equal("start_cnt", 32'd0, rd);
        axi_read(REG_STOP_CNT, 0, rd, resp);
        check_equal("stop_cnt", 32'd0, rd);

        // register access and back-pressure
        axi_write(REG_CTRL, 32'h0123_0000, 0, resp);
        check_equal("bresp ctrl", RESP_OKAY, resp);
        axi_read(REG_CTRL, 4, rd, resp);
        check_equal("ctrl readback", 32'h0123_0000, rd);
        axi_read(8'h20, 0, rd, resp);
        check_equal("rresp unmapped", RESP_SLVERR, resp);
        check_equal("rdata unmapped", 32'd0, rd);
        axi_write(8'h20, 32'hFFFF_FFFF, 4, resp);
        check_equal("bresp unmapped", RESP_SLVERR, resp);
        axi_read(REG_CTRL, 0, rd, resp);
        check_equal("ctrl after unmapped write", 32'h0123_0000, rd);

        // side a sda to side b
        axi_write(REG_CTRL, {DIV, 16'd0}, 0, resp); // tick counter reloads from this while off
        axi_write(REG_CTRL, {DIV, 16'd1}, 0, resp);
        wait_cycles(BOUND);
        dev_low[0] = 1'b1;
        expect_pull(2, 1'b1, "b_sda_pull");
        axi_read(REG_STATUS, 0, rd, resp);
        check_equal("status.sda_owner", OWN_A, rd[2:1]);
        dev_low[0] = 1'b0;
        expect_pull(2, 1'b0, "b_sda_pull");
        wait_cycles(BOUND); // settle tick back to idle
        axi_read(REG_STATUS, 0, rd, resp);
        check_equal("status.sda_owner", OWN_NONE, rd[2:1]);

        // side b scl to side a
        dev_low[3] = 1'b1;
        expect_pull(1, 1'b1, "a_scl_pull");
        axi_read(REG_STATUS, 0, rd, resp);
        check_equal("status.scl_owner", OWN_B, rd[4:3]);
        dev_low[3] = 1'b0;
        expect_pull(1, 1'b0, "a_scl_pull");
        wait_cycles(BOUND);
        axi_read(REG_STATUS, 0, rd, resp);
        check_equal("status.scl_owner", OWN_NONE, rd[4:3]);

        // disabled bridge passes nothing
        axi_write(REG_CTRL, {DIV, 16'd0}, 0, resp);
        dev_low[0] = 1'b1;
        expect_quiet(2 * BOUND);
        dev_low[0] = 1'b0;
        dev_low[3] = 1'b1;
        expect_quiet(2 * BOUND);
        dev_low[3] = 1'b0;
        wait_cycles(BOUND);

        // random traffic against the reference count
        axi_write(REG_CTRL, {DIV, 16'd1}, 0, resp);
        axi_write(REG_CLEAR, 32'd0, 0, resp); // drop events from the directed tests
        wait_cycles(BOUND);
        lfsr        = 16'd9126;
        sda_hist[0] = 1'b1;
        scl_hist[0] = 1'b1;
        for (int i = 0; i < RAND_STEPS; i++)
        begin
            take_bit(side);
            take_bit(line);
            take_bit(dir);
            dev_low[{side, line}] = dir; // 1 pulls low, 0 releases
            wait_cycles(2 * BOUND); // owner hand-over can take several ticks
            sda_hist[i+1] = !(dev_low[0] || dev_low[2]);
            scl_hist[i+1] = !(dev_low[1] || dev_low[3]);
        end
        axi_read(REG_START_CNT, 0, rd, resp);
        check_equal("start_cnt", count_conditions(RAND_STEPS, 1'b1), rd);
        axi_read(REG_STOP_CNT, 0, rd, resp);
        check_equal("stop_cnt", count_conditions(RAND_STEPS, 1'b0), rd);
        axi_write(REG_CLEAR, 32'd0, 0, resp);
        axi_read(REG_START_CNT, 0, rd, resp);
        check_equal("start_cnt after clear", 32'd0, rd);
        axi_read(REG_STOP_CNT, 0, rd, resp);
        check_equal("stop_cnt after clear", 32'd0, rd);

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // run limit from the number of bounded waits
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

// free running clock plus power-on reset for the testbench
module tb_clk_gen
#(
    parameter real PERIOD       = 10.0,
    parameter int  RESET_CYCLES = 10
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0; // same 1 ns skew as the stimulus
    end

endmodule

//--- verilog/i2c_bridge_top.sv
`timescale 1ns/1ps

// side a is the video connector ddc, side b the companion mcu
module i2c_bridge_top
    import bridge_pkg::*;
#(
    parameter logic [15:0] DEFAULT_DIV = 16'd8
)
(
    input  logic          clk,
    input  logic          rst,
    input  axi_lite_req_t axi_req,
    output axi_lite_rsp_t axi_rsp,
    input  logic          a_sda_in,
    input  logic          a_scl_in,
    input  logic          b_sda_in,
    input  logic          b_scl_in,
    output logic          a_sda_pull,
    output logic          a_scl_pull,
    output logic          b_sda_pull,
    output logic          b_scl_pull
);

    bridge_ctrl_t ctrl;
    logic         counter_clear;
    logic         tick;
    line_owner_e  sda_owner;
    line_owner_e  scl_owner;
    logic         sda_level; // synced bridged levels
    logic         scl_level;
    logic         busy;
    logic [15:0]  start_cnt;
    logic [15:0]  stop_cnt;

    bridge_regs #(
        .DEFAULT_DIV(DEFAULT_DIV)
    ) bridge_regs_inst (
        .clk          (clk),
        .rst          (rst),
        .axi_req      (axi_req),
        .axi_rsp      (axi_rsp),
        .ctrl         (ctrl),
        .counter_clear(counter_clear),
        .sda_owner    (sda_owner),
        .scl_owner    (scl_owner),
        .busy         (busy),
        .start_cnt    (start_cnt),
        .stop_cnt     (stop_cnt)
    );

    bridge_tick_gen tick_gen_inst (
        .clk (clk),
        .rst (rst),
        .ctrl(ctrl),
        .tick(tick)
    );

    i2c_line_bridge sda_bridge (
        .clk       (clk),
        .rst       (rst),
        .enable    (ctrl.enable),
        .tick      (tick),
        .a_in      (a_sda_in),
        .b_in      (b_sda_in),
        .a_pull    (a_sda_pull),
        .b_pull    (b_sda_pull),
        .owner     (sda_owner),
        .line_level(sda_level)
    );

    i2c_line_bridge scl_bridge (
        .clk       (clk),
        .rst       (rst),
        .enable    (ctrl.enable),
        .tick      (tick),
        .a_in      (a_scl_in),
        .b_in      (b_scl_in),
        .a_pull    (a_scl_pull),
        .b_pull    (b_scl_pull),
        .owner     (scl_owner),
        .line_level(scl_level)
    );

    i2c_bus_monitor monitor_inst (
        .clk      (clk),
        .rst      (rst),
        .clear    (counter_clear),
        .sda      (sda_level),
        .scl      (scl_level),
        .busy     (busy),
        .start_cnt(start_cnt),
        .stop_cnt (stop_cnt)
    );

endmodule

//--- verilog/bridge_regs.sv
`timescale 1ns/1ps

// AXI4-Lite register block
// CTRL bit 0 enable, bits 31:16 tick_div
module bridge_regs
    import bridge_pkg::*;
#(
    parameter logic [15:0] DEFAULT_DIV = 16'd8
)
(
    input  logic          clk,
    input  logic          rst,
    input  axi_lite_req_t axi_req,
    output axi_lite_rsp_t axi_rsp,
    output bridge_ctrl_t  ctrl,
    output logic          counter_clear,
    input  line_owner_e   sda_owner,
    input  line_owner_e   scl_owner,
    input  logic          busy,
    input  logic [15:0]   start_cnt,
    input  logic [15:0]   stop_cnt
);

    logic         ready_en; // low only for the reset cycle
    logic         aw_held;
    logic         w_held;
    logic [7:0]   aw_addr;
    logic [31:0]  w_data;
    logic [3:0]   w_strb;
    logic         bvalid;
    logic [1:0]   bresp;
    logic         rvalid;
    logic [1:0]   rresp;
    logic [31:0]  rdata;
    logic         awready;
    logic         wready;
    logic         arready;
    logic         aw_fire;
    logic         w_fire;
    logic         ar_fire;
    logic [31:0]  rd_data;
    logic [1:0]   rd_resp;
    bridge_ctrl_t ctrl_q;

    function automatic logic addr_mapped(input logic [7:0] addr);
        return (addr == REG_CTRL) || (addr == REG_STATUS) || (addr == REG_START_CNT) ||
               (addr == REG_STOP_CNT) || (addr == REG_CLEAR);
    endfunction

    // each ready drops once its part is captured or a response is pending
    assign awready = ready_en && !aw_held && !bvalid;
    assign wready  = ready_en && !w_held && !bvalid;
    assign arready = ready_en && !rvalid;

    assign aw_fire = axi_req.awvalid && awready;
    assign w_fire  = axi_req.wvalid && wready;
    assign ar_fire = axi_req.arvalid && arready;

    always_ff @(posedge clk)
    begin
        if (rst)
            ready_en <= 1'b0;
        else
            ready_en <= 1'b1;
    end

    // captured address and data, payload only
    always_ff @(posedge clk)
    begin
        if (aw_fire)
            aw_addr <= axi_req.awaddr;
        if (w_fire)
        begin
            w_data <= axi_req.wdata;
            w_strb <= axi_req.wstrb;
        end
    end

    // write channel and register updates
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            aw_held         <= 1'b0;
            w_held          <= 1'b0;
            bvalid          <= 1'b0;
            bresp           <= RESP_OKAY;
            ctrl_q.enable   <= 1'b0;
            ctrl_q.tick_div <= DEFAULT_DIV;
            counter_clear   <= 1'b0;
        end
        else
        begin
            counter_clear <= 1'b0; // single cycle pulse
            if (aw_fire)
                aw_held <= 1'b1;
            if (w_fire)
                w_held <= 1'b1;
            if (bvalid && axi_req.bready)
                bvalid <= 1'b0;
            if (aw_held && w_held) // both halves in, commit
            begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= addr_mapped(aw_addr) ? RESP_OKAY : RESP_SLVERR;
                if (aw_addr == REG_CTRL)
                begin
                    if (w_strb[0])
                        ctrl_q.enable <= w_data[0];
                    if (w_strb[2])
                        ctrl_q.tick_div[7:0] <= w_data[23:16];
                    if (w_strb[3])
                        ctrl_q.tick_div[15:8] <= w_data[31:24];
                end
                if (aw_addr == REG_CLEAR)
                    counter_clear <= 1'b1; // data ignored
            end
        end
    end

    // read mux, status and counters are read only
    always_comb
    begin
        rd_data = 32'd0;
        rd_resp = RESP_OKAY;
        case (axi_req.araddr)
            REG_CTRL:      rd_data = {ctrl_q.tick_div, 15'd0, ctrl_q.enable};
            REG_STATUS:    rd_data = {27'd0, scl_owner, sda_owner, busy};
            REG_START_CNT: rd_data = {16'd0, start_cnt};
            REG_STOP_CNT:  rd_data = {16'd0, stop_cnt};
            REG_CLEAR:     rd_data = 32'd0; // write-only strobe
            default:       rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end
        else if (ar_fire)
        begin
            rvalid <= 1'b1;
            rresp  <= rd_resp;
        end
        else if (rvalid && axi_req.rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (ar_fire)
            rdata <= rd_data; // held while rvalid waits
    end

    always_comb
    begin
        axi_rsp.awready = awready;
        axi_rsp.wready  = wready;
        axi_rsp.bvalid  = bvalid;
        axi_rsp.bresp   = bresp;
        axi_rsp.arready = arready;
        axi_rsp.rvalid  = rvalid;
        axi_rsp.rdata   = rdata;
        axi_rsp.rresp   = rresp;
    end

    assign ctrl = ctrl_q;

endmodule

//--- i2c_bridge/i2c_bus_monitor.sv
`timescale 1ns/1ps

// START / STOP detector on the bridged bus levels
module i2c_bus_monitor
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        sda,
    input  logic        scl,
    output logic        busy,
    output logic [15:0] start_cnt,
    output logic [15:0] stop_cnt
);

    logic sda_q;     // sda one clock ago
    logic start_det;
    logic stop_det;

    always_ff @(posedge clk)
    begin
        if (rst)
            sda_q <= 1'b1;
        else
            sda_q <= sda;
    end

    // data may only change while scl is low, so an edge with scl high is a condition
    assign start_det = sda_q && !sda && scl;
    assign stop_det  = !sda_q && sda && scl;

    always_ff @(posedge clk)
    begin
        if (rst)
            busy <= 1'b0;
        else if (start_det)
            busy <= 1'b1;
        else if (stop_det)
            busy <= 1'b0; // bus free again
    end

    // counters wrap at 16 bits
    always_ff @(posedge clk)
    begin
        if (rst || clear)
        begin
            start_cnt <= 16'd0;
            stop_cnt  <= 16'd0;
        end
        else
        begin
            if (start_det)
                start_cnt <= start_cnt + 16'd1;
            if (stop_det)
                stop_cnt <= stop_cnt + 16'd1;
        end
    end

endmodule

//--- i2c_bridge/i2c_line_bridge.sv
`timescale 1ns/1ps

// one open-drain line shared between side a and side b
// whoever pulls low first owns the line, the bridge copies the low to the other side
module i2c_line_bridge
    import bridge_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        tick,
    input  logic        a_in,
    input  logic        b_in,
    output logic        a_pull,
    output logic        b_pull,
    output line_owner_e owner,
    output logic        line_level
);

    logic [1:0]  a_sync; // two flop synchronizers
    logic [1:0]  b_sync;
    logic        a_s;
    logic        b_s;
    line_owner_e owner_q;
    line_owner_e owner_next;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_sync <= 2'b11; // idle bus is high
            b_sync <= 2'b11;
        end
        else
        begin
            a_sync <= {a_sync[0], a_in};
            b_sync <= {b_sync[0], b_in};
        end
    end

    assign a_s = a_sync[1];
    assign b_s = b_sync[1];

    // ownership steps, evaluated only on tick
    always_comb
    begin
        owner_next = owner_q;
        case (owner_q)
            OWN_NONE:
            begin
                if (!a_s)
                    owner_next = OWN_A; // a wins a tie
                else if (!b_s)
                    owner_next = OWN_B;
            end
            OWN_A:
                if (a_s)
                    owner_next = OWN_SETTLE; // a let go
            OWN_B:
                if (b_s)
                    owner_next = OWN_SETTLE;
            default:
                owner_next = OWN_NONE; // settle lasts one tick
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || !enable)
            owner_q <= OWN_NONE;
        else if (tick)
            owner_q <= owner_next;
    end

    // settle keeps us from seeing our own low on the far side as a new owner
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_pull <= 1'b0;
            b_pull <= 1'b0;
        end
        else
        begin
            a_pull <= (owner_q == OWN_B); // mirror b onto a
            b_pull <= (owner_q == OWN_A);
        end
    end

    assign owner      = owner_q;
    assign line_level = a_s & b_s; // wired-and of both synced pins

endmodule

//--- verilog/bridge_tick_gen.sv
`timescale 1ns/1ps

// slow clock enable for the line bridges
module bridge_tick_gen
    import bridge_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  bridge_ctrl_t ctrl,
    output logic         tick
);

    logic [15:0] cnt; // counts down to zero, then reloads

    always_ff @(posedge clk)
    begin
        if (rst || !ctrl.enable)
        begin
            cnt  <= ctrl.tick_div; // held in reload, first tick a full period later
            tick <= 1'b0;
        end
        else if (cnt == 16'd0)
        begin
            cnt  <= ctrl.tick_div; // new divider only picked up here
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 16'd1;
            tick <= 1'b0;
        end
    end

endmodule

//--- common/bridge_pkg.sv
package bridge_pkg;

    // AXI4-Lite master to slave, 8-bit address space
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axi_lite_req_t;

    // AXI4-Lite slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_lite_rsp_t;

    // which side holds a bridged line low
    typedef enum logic [1:0] {
        OWN_NONE   = 2'd0,
        OWN_A      = 2'd1, // side a low, drive side b
        OWN_B      = 2'd2, // side b low, drive side a
        OWN_SETTLE = 2'd3  // one tick of quiet after release
    } line_owner_e;

    typedef struct packed {
        logic        enable;
        logic [15:0] tick_div; // tick every tick_div+1 clocks
    } bridge_ctrl_t;

    // register map, byte offsets
    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_STATUS    = 8'h04;
    localparam logic [7:0] REG_START_CNT = 8'h08;
    localparam logic [7:0] REG_STOP_CNT  = 8'h0C;
    localparam logic [7:0] REG_CLEAR     = 8'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
